/* cache_top.f */
logic/cache_geometry_pkg.sv
logic/cache_bus_pkg.sv
logic/cache_tag_array.sv
logic/cache_data_array.sv
logic/cache_controller.sv
logic/cache_top.sv
verification/cache_mem_model.sv
verification/cache_tb.sv

/* logic/cache_bus_pkg.sv */
package cache_bus_pkg;

    // processor side, held steady while stalled
    typedef struct packed {
        logic                           read;
        logic                           write;
        cache_geometry_pkg::word_addr_u addr;
        cache_geometry_pkg::word_t      wdata;
    } proc_req_t;

    // memory side, one of read or write held until ready
    typedef struct packed {
        logic                                       read;
        logic                                       write;
        logic [cache_geometry_pkg::LINE_ADDR_W-1:0] line_addr;
        cache_geometry_pkg::line_t                  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      ready; // one cycle per transaction
        cache_geometry_pkg::line_t rdata;
    } mem_resp_t;

endpackage

/* logic/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
    input  logic                     clk,
    input  logic                     proc_reset,
    input  cache_bus_pkg::proc_req_t proc_req,
    input  cache_bus_pkg::mem_resp_t mem_resp,
    input  logic                     hit,
    input  cache_geometry_pkg::way_t hit_way,
    input  cache_geometry_pkg::way_t victim_way,
    input  logic                     victim_dirty,
    input  cache_geometry_pkg::tag_t victim_tag,
    input  cache_geometry_pkg::line_t victim_line,
    output logic                     proc_stall,
    output cache_bus_pkg::mem_req_t  mem_req,
    output cache_geometry_pkg::way_t access_way,
    output logic                     touch,
    output logic                     fill,
    output logic                     fill_dirty,
    output logic                     set_dirty,
    output logic                     write_word,
    output logic                     fill_line
);

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        ALLOCATE
    } state_t;

    state_t state;
    state_t state_next;

    logic req_valid;
    logic idle_hit;
    logic miss;
    logic refill_done;

    assign req_valid   = proc_req.read | proc_req.write;
    assign idle_hit    = (state == IDLE) & req_valid & hit;
    assign miss        = (state == IDLE) & req_valid & ~hit;
    assign refill_done = (state == ALLOCATE) & mem_resp.ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    // dirty victim goes out before the refill
                    state_next = victim_dirty ? WRITEBACK : ALLOCATE;
                end
            end
            WRITEBACK: begin
                if (mem_resp.ready) begin
                    state_next = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (mem_resp.ready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // victim way stays put during a miss since mru only moves on touch or fill
    assign access_way = (state == IDLE) ? hit_way : victim_way;

    always_comb begin
        case (state)
            IDLE:      proc_stall = miss;
            WRITEBACK: proc_stall = 1'b1;
            ALLOCATE:  proc_stall = ~mem_resp.ready; // released on the refill edge
            default:   proc_stall = 1'b1;
        endcase
    end

    always_comb begin
        mem_req.read  = (state == ALLOCATE);
        mem_req.write = (state == WRITEBACK);
        if (state == WRITEBACK) begin
            mem_req.line_addr = {victim_tag, proc_req.addr.fields.index};
        end else begin
            mem_req.line_addr = proc_req.addr.line.line_addr;
        end
        mem_req.wdata = victim_line;
    end

    // array strobes
    assign touch      = idle_hit;
    assign set_dirty  = idle_hit & proc_req.write;
    assign write_word = (idle_hit | refill_done) & proc_req.write;
    assign fill       = refill_done;
    assign fill_line  = refill_done;
    assign fill_dirty = proc_req.write; // write-allocate leaves the line dirty

endmodule

/* logic/cache_data_array.sv */
`timescale 1ns/1ps

module cache_data_array (
    input  logic                        clk,
    input  cache_geometry_pkg::index_t  index,
    input  cache_geometry_pkg::offset_t offset,
    input  cache_geometry_pkg::way_t    access_way,
    input  cache_geometry_pkg::word_t   wdata,
    input  logic                        write_word,
    input  logic                        fill_line,
    input  cache_geometry_pkg::line_t   fill_data,
    output cache_geometry_pkg::word_t   rd_word,
    output cache_geometry_pkg::line_t   victim_line
);

    cache_geometry_pkg::line_t lines [cache_geometry_pkg::NUM_SETS][cache_geometry_pkg::NUM_WAYS];

    cache_geometry_pkg::line_t stored_line;
    cache_geometry_pkg::line_t new_line;

    assign stored_line = lines[index][access_way];
    assign victim_line = stored_line; // read out during write-back

    // incoming line or stored line, with the processor word merged in
    always_comb begin
        new_line = fill_line ? fill_data : stored_line;
        if (write_word) begin
            new_line[offset*cache_geometry_pkg::WORD_W +: cache_geometry_pkg::WORD_W] = wdata;
        end
    end

    always_comb begin
        if (fill_line) begin
            // refill cycle, forward from the arriving line
            rd_word = new_line[offset*cache_geometry_pkg::WORD_W +: cache_geometry_pkg::WORD_W];
        end else begin
            rd_word = stored_line[offset*cache_geometry_pkg::WORD_W +: cache_geometry_pkg::WORD_W];
        end
    end

    always_ff @(posedge clk) begin
        if (fill_line || write_word) begin
            lines[index][access_way] <= new_line;
        end
    end

endmodule

/* logic/cache_geometry_pkg.sv */
package cache_geometry_pkg;

    // word and line sizes
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W; // 128

    // organization
    localparam int NUM_SETS = 4;
    localparam int NUM_WAYS = 2;

    // 30-bit word address split as tag | index | offset
    localparam int OFFSET_W    = $clog2(WORDS_PER_LINE);
    localparam int INDEX_W     = $clog2(NUM_SETS);
    localparam int TAG_W       = 26;
    localparam int LINE_ADDR_W = TAG_W + INDEX_W; // 28

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t; // word 0 in bits 31:0
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic                way_t;

    // lookup view
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_fields_t;

    // memory view
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
        offset_t                offset;
    } addr_line_t;

    typedef union packed {
        addr_fields_t fields;
        addr_line_t   line;
    } word_addr_u;

endpackage

/* logic/cache_tag_array.sv */
`timescale 1ns/1ps

module cache_tag_array (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  cache_geometry_pkg::index_t index,
    input  cache_geometry_pkg::tag_t   tag,
    input  logic                       touch,
    input  logic                       fill,
    input  logic                       fill_dirty,
    input  logic                       set_dirty,
    input  cache_geometry_pkg::way_t   access_way,
    output logic                       hit,
    output cache_geometry_pkg::way_t   hit_way,
    output cache_geometry_pkg::way_t   victim_way,
    output logic                       victim_dirty,
    output cache_geometry_pkg::tag_t   victim_tag
);

    cache_geometry_pkg::tag_t tags [cache_geometry_pkg::NUM_SETS][cache_geometry_pkg::NUM_WAYS];

    logic [cache_geometry_pkg::NUM_WAYS-1:0] valid [cache_geometry_pkg::NUM_SETS];
    logic [cache_geometry_pkg::NUM_WAYS-1:0] dirty [cache_geometry_pkg::NUM_SETS];

    // most recently used way per set
    cache_geometry_pkg::way_t mru [cache_geometry_pkg::NUM_SETS];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < cache_geometry_pkg::NUM_WAYS; w++) begin
            if (valid[index][w] && tags[index][w] == tag) begin
                hit     = 1'b1;
                hit_way = cache_geometry_pkg::way_t'(w);
            end
        end
    end

    assign victim_way   = ~mru[index]; // the other way
    assign victim_dirty = valid[index][victim_way] & dirty[index][victim_way];
    assign victim_tag   = tags[index][victim_way];

    // tags only matter once valid is set
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index][access_way] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < cache_geometry_pkg::NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                mru[s]   <= '0;
            end
        end else begin
            if (fill) begin
                valid[index][access_way] <= 1'b1;
                dirty[index][access_way] <= fill_dirty;
                mru[index]               <= access_way;
            end else begin
                if (touch) begin
                    mru[index] <= access_way;
                end
                if (set_dirty) begin
                    dirty[index][access_way] <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
    input  logic                      clk,
    input  logic                      proc_reset,
    input  cache_bus_pkg::proc_req_t  proc_req,
    output cache_geometry_pkg::word_t proc_rdata,
    output logic                      proc_stall,
    output cache_bus_pkg::mem_req_t   mem_req,
    input  cache_bus_pkg::mem_resp_t  mem_resp
);

    logic                      hit;
    cache_geometry_pkg::way_t  hit_way;
    cache_geometry_pkg::way_t  victim_way;
    logic                      victim_dirty;
    cache_geometry_pkg::tag_t  victim_tag;
    cache_geometry_pkg::line_t victim_line;
    cache_geometry_pkg::way_t  access_way;
    logic                      touch;
    logic                      fill;
    logic                      fill_dirty;
    logic                      set_dirty;
    logic                      write_word;
    logic                      fill_line;

    cache_tag_array u_tags (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (proc_req.addr.fields.index),
        .tag          (proc_req.addr.fields.tag),
        .touch        (touch),
        .fill         (fill),
        .fill_dirty   (fill_dirty),
        .set_dirty    (set_dirty),
        .access_way   (access_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_data_array u_data (
        .clk         (clk),
        .index       (proc_req.addr.fields.index),
        .offset      (proc_req.addr.fields.offset),
        .access_way  (access_way),
        .wdata       (proc_req.wdata),
        .write_word  (write_word),
        .fill_line   (fill_line),
        .fill_data   (mem_resp.rdata),
        .rd_word     (proc_rdata),
        .victim_line (victim_line)
    );

    cache_controller u_ctrl (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_req     (proc_req),
        .mem_resp     (mem_resp),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .proc_stall   (proc_stall),
        .mem_req      (mem_req),
        .access_way   (access_way),
        .touch        (touch),
        .fill         (fill),
        .fill_dirty   (fill_dirty),
        .set_dirty    (set_dirty),
        .write_word   (write_word),
        .fill_line    (fill_line)
    );

endmodule

/* verification/cache_mem_model.sv */
`timescale 1ns/1ps

module cache_mem_model (
    input  logic                                       clk,
    input  logic                                       proc_reset,
    input  cache_bus_pkg::mem_req_t                    mem_req,
    output cache_bus_pkg::mem_resp_t                   mem_resp,
    output int                                         rd_count,
    output int                                         wr_count,
    output logic [cache_geometry_pkg::LINE_ADDR_W-1:0] last_rd_addr,
    output logic [cache_geometry_pkg::LINE_ADDR_W-1:0] last_wr_addr,
    output cache_geometry_pkg::line_t                  last_wr_data
);

    localparam int LATENCY  = 4;
    localparam int MAX_KEPT = 64;

    // lines written back so far, everything else reads as the preset pattern
    logic [cache_geometry_pkg::LINE_ADDR_W-1:0] written_addr [MAX_KEPT];
    cache_geometry_pkg::line_t                  written_line [MAX_KEPT];
    int                                         written_n;
    int                                         wait_cnt;

    function automatic cache_geometry_pkg::word_t preset_word(input logic [29:0] word_addr);
        return {word_addr, 2'b00} ^ 32'ha5c3_1e0f;
    endfunction

    function automatic int find_line(input logic [27:0] line_addr);
        int found;
        found = -1;
        for (int i = 0; i < written_n; i++) begin
            if (written_addr[i] == line_addr) found = i;
        end
        return found;
    endfunction

    function automatic cache_geometry_pkg::line_t read_line(input logic [27:0] line_addr);
        cache_geometry_pkg::line_t line;
        int                        slot;
        slot = find_line(line_addr);
        if (slot >= 0) begin
            line = written_line[slot];
        end else begin
            for (int w = 0; w < 4; w++) begin
                line[w*32 +: 32] = preset_word({line_addr, 2'(w)});
            end
        end
        return line;
    endfunction

    always @(posedge clk) begin
        int slot;
        if (proc_reset) begin
            mem_resp     <= '0;
            wait_cnt     <= 0;
            written_n    = 0;
            rd_count     <= 0;
            wr_count     <= 0;
            last_rd_addr <= '0;
            last_wr_addr <= '0;
            last_wr_data <= '0;
        end else begin
            mem_resp.ready <= 1'b0;
            if (mem_resp.ready) begin
                wait_cnt <= 0; // request still up this cycle is the finished one
            end else if (mem_req.read || mem_req.write) begin
                if (wait_cnt == LATENCY - 1) begin
                    wait_cnt       <= 0;
                    mem_resp.ready <= 1'b1;
                    if (mem_req.write) begin
                        slot = find_line(mem_req.line_addr);
                        if (slot < 0) begin
                            slot      = written_n;
                            written_n = written_n + 1;
                        end
                        written_addr[slot] = mem_req.line_addr;
                        written_line[slot] = mem_req.wdata;
                        wr_count     <= wr_count + 1;
                        last_wr_addr <= mem_req.line_addr;
                        last_wr_data <= mem_req.wdata;
                    end else begin
                        mem_resp.rdata <= read_line(mem_req.line_addr);
                        rd_count       <= rd_count + 1;
                        last_rd_addr   <= mem_req.line_addr;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule

/* verification/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    localparam int CYCLE_LIMIT = 4000;

    logic                                       clk = 1'b0;
    logic                                       proc_reset;
    cache_bus_pkg::proc_req_t                   proc_req;
    cache_geometry_pkg::word_t                  proc_rdata;
    logic                                       proc_stall;
    cache_bus_pkg::mem_req_t                    mem_req;
    cache_bus_pkg::mem_resp_t                   mem_resp;
    int                                         rd_count;
    int                                         wr_count;
    logic [cache_geometry_pkg::LINE_ADDR_W-1:0] last_rd_addr;
    logic [cache_geometry_pkg::LINE_ADDR_W-1:0] last_wr_addr;
    cache_geometry_pkg::line_t                  last_wr_data;

    integer seed = 41276;
    int     cycles = 0;
    int     errors = 0;
    int     start_errors;
    int     tests_run = 0;
    int     tests_failed = 0;

    // flat shadow of the random test's 16 lines
    cache_geometry_pkg::word_t shadow_word [64];
    logic                      shadow_valid [64];

    always #4 clk = ~clk;

    cache_top dut (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

    cache_mem_model u_mem (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .rd_count     (rd_count),
        .wr_count     (wr_count),
        .last_rd_addr (last_rd_addr),
        .last_wr_addr (last_wr_addr),
        .last_wr_data (last_wr_data)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic cache_geometry_pkg::word_t preset_word(input logic [29:0] word_addr);
        return {word_addr, 2'b00} ^ 32'ha5c3_1e0f;
    endfunction

    function automatic cache_geometry_pkg::line_t preset_line(input logic [27:0] line_addr);
        cache_geometry_pkg::line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = preset_word({line_addr, 2'(w)});
        end
        return line;
    endfunction

    function automatic logic [29:0] make_addr(input logic [25:0] tag, input logic [1:0] index,
                                              input logic [1:0] offset);
        return {tag, index, offset};
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("Fail %s: got %0h, expected %0h", name, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == start_errors) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    // one processor access, returns once the completing edge has passed
    task automatic access(input logic write, input logic [29:0] addr,
                          input cache_geometry_pkg::word_t wdata,
                          output cache_geometry_pkg::word_t rdata, output int stalls);
        stalls         = 0;
        proc_req.read  = !write;
        proc_req.write = write;
        proc_req.addr  = addr;
        proc_req.wdata = wdata;
        @(negedge clk);
        while (proc_stall) begin
            stalls++;
            @(negedge clk);
        end
        rdata = proc_rdata;
        @(posedge clk);
        #1;
        proc_req.read  = 1'b0;
        proc_req.write = 1'b0;
    endtask

    task automatic reset_idle_check();
        start_errors = errors;
        repeat (20) begin
            @(negedge clk);
            if (proc_stall || mem_req.read || mem_req.write) begin
                report_problem("stall or memory request raised with no request driven");
            end
        end
        if (rd_count != 0 || wr_count != 0) begin
            report_problem("memory transaction seen with no request driven");
        end
        @(posedge clk);
        #1;
        finish_test("reset and idle");
    endtask

    task automatic cold_read_miss();
        logic [29:0]               a;
        cache_geometry_pkg::word_t rdata;
        int                        stalls;
        int                        rd0;
        int                        wr0;
        start_errors = errors;
        a   = make_addr(26'h12, 2'd0, 2'd1);
        rd0 = rd_count;
        wr0 = wr_count;
        access(1'b0, a, '0, rdata, stalls);
        if (stalls == 0) report_problem("cold read miss did not stall");
        if (rd_count - rd0 != 1) report_mismatch("rd_count delta", rd_count - rd0, 1);
        if (wr_count != wr0) report_mismatch("wr_count", wr_count, wr0);
        if (last_rd_addr !== a[29:2]) report_mismatch("mem_req.line_addr", last_rd_addr, a[29:2]);
        if (rdata !== preset_word(a)) report_mismatch("proc_rdata", rdata, preset_word(a));
        finish_test("cold read miss");
    endtask

    task automatic same_line_hits();
        logic [29:0]               b;
        cache_geometry_pkg::word_t rdata;
        int                        stalls;
        int                        rd0;
        int                        wr0;
        start_errors = errors;
        b   = make_addr(26'h12, 2'd0, 2'd3);
        rd0 = rd_count;
        wr0 = wr_count;
        access(1'b0, b, '0, rdata, stalls);
        if (stalls != 0) report_problem("read hit stalled");
        if (rdata !== preset_word(b)) report_mismatch("proc_rdata", rdata, preset_word(b));
        access(1'b1, b, 32'hdead_beef, rdata, stalls);
        if (stalls != 0) report_problem("write hit stalled");
        access(1'b0, b, '0, rdata, stalls);
        if (stalls != 0) report_problem("read after write hit stalled");
        if (rdata !== 32'hdead_beef) report_mismatch("proc_rdata", rdata, 32'hdead_beef);
        if (rd_count != rd0 || wr_count != wr0) report_problem("memory traffic on a hit");
        finish_test("same line hits");
    endtask

    task automatic dirty_eviction();
        logic [29:0]               x;
        cache_geometry_pkg::word_t rdata;
        cache_geometry_pkg::line_t exp_line;
        int                        stalls;
        int                        wr0;
        start_errors = errors;
        x   = make_addr(26'h100, 2'd1, 2'd2);
        wr0 = wr_count;
        access(1'b1, x, 32'h1234_5678, rdata, stalls);
        access(1'b0, make_addr(26'h200, 2'd1, 2'd0), '0, rdata, stalls);
        if (wr_count != wr0) report_mismatch("wr_count", wr_count, wr0);
        // x is now least recent and dirty
        access(1'b0, make_addr(26'h300, 2'd1, 2'd0), '0, rdata, stalls);
        exp_line          = preset_line(x[29:2]);
        exp_line[95:64]   = 32'h1234_5678;
        if (wr_count - wr0 != 1) report_mismatch("wr_count delta", wr_count - wr0, 1);
        if (last_wr_addr !== x[29:2]) report_mismatch("mem_req.line_addr", last_wr_addr, x[29:2]);
        if (last_wr_data !== exp_line) report_mismatch("mem_req.wdata", last_wr_data, exp_line);
        access(1'b0, x, '0, rdata, stalls);
        if (stalls == 0) report_problem("read of evicted line did not miss");
        if (rdata !== 32'h1234_5678) report_mismatch("proc_rdata", rdata, 32'h1234_5678);
        if (wr_count - wr0 != 1) report_problem("clean victim was written back");
        finish_test("dirty eviction");
    endtask

    task automatic write_allocate();
        logic [29:0]               a;
        cache_geometry_pkg::word_t rdata;
        cache_geometry_pkg::word_t exp;
        int                        stalls;
        int                        rd0;
        int                        wr0;
        start_errors = errors;
        rd0 = rd_count;
        wr0 = wr_count;
        access(1'b1, make_addr(26'h55, 2'd2, 2'd1), 32'hcafe_f00d, rdata, stalls);
        if (stalls == 0) report_problem("write miss did not stall");
        if (wr_count != wr0) report_mismatch("wr_count", wr_count, wr0);
        if (rd_count - rd0 != 1) report_mismatch("rd_count delta", rd_count - rd0, 1);
        for (int o = 0; o < 4; o++) begin
            a   = make_addr(26'h55, 2'd2, 2'(o));
            exp = (o == 1) ? 32'hcafe_f00d : preset_word(a);
            access(1'b0, a, '0, rdata, stalls);
            if (stalls != 0) report_problem("read of allocated line stalled");
            if (rdata !== exp) report_mismatch("proc_rdata", rdata, exp);
        end
        if (rd_count - rd0 != 1) report_problem("extra memory read after allocation");
        finish_test("write allocate");
    endtask

    task automatic random_mix();
        logic [29:0]               a;
        cache_geometry_pkg::word_t wdata;
        cache_geometry_pkg::word_t rdata;
        cache_geometry_pkg::word_t exp;
        int                        stalls;
        int                        r;
        int                        slot;
        start_errors = errors;
        for (int i = 0; i < 64; i++) shadow_valid[i] = 1'b0;
        for (int i = 0; i < 200; i++) begin
            r     = $random(seed);
            wdata = $random(seed);
            slot  = r[7:2]; // line in 5:2, word in 7:6
            a     = make_addr(26'h2000 + r[5:4], r[3:2], r[7:6]);
            access(r[0], a, wdata, rdata, stalls);
            if (r[0]) begin
                shadow_word[slot]  = wdata;
                shadow_valid[slot] = 1'b1;
            end else begin
                exp = shadow_valid[slot] ? shadow_word[slot] : preset_word(a);
                if (rdata !== exp) report_mismatch("proc_rdata", rdata, exp);
            end
        end
        finish_test("random mix");
    endtask

    initial begin
        proc_reset = 1'b1;
        proc_req   = '0;
        repeat (16) @(posedge clk);
        #1;
        proc_reset = 1'b0;
        reset_idle_check();
        cold_read_miss();
        same_line_hits();
        dirty_eviction();
        write_allocate();
        random_mix();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
